//--- list.f
rtl/msx_pkg.sv
rtl/ppi_ports.sv
rtl/slot_memory.sv
rtl/wait_gen.sv
rtl/audio_mix.sv
rtl/msx_core.sv
sim/tb_msx_core.sv

//--- rtl/audio_mix.sv
`timescale 1ns/10ps

module audio_mix (
   input  logic              clock_bus,
   input  logic              rst,
   input  msx_pkg::sample_t  device_sound_l,
   input  msx_pkg::sample_t  device_sound_r,
   input  logic              keybeep,
   input  logic              tape_in,
   input  logic              tape_motor_on,
   output msx_pkg::sample_t  audio_l,
   output msx_pkg::sample_t  audio_r
);

   import msx_pkg::*;

   logic [9:0]  sys_sound;
   logic [16:0] sum_l;
   logic [16:0] sum_r;

   // Clip a 17-bit sum into one output sample
   function automatic sample_t saturate(input logic [16:0] sum);
      sample_t result;
      case (sum[16:14])
         3'b000, 3'b111: result = {sum[16], sum[13:0], 1'b0};
         default:        result = sum[16] ? 16'h8000 : 16'h7FFF;
      endcase
      return result;
   endfunction

   // Key click plus tape monitor while the motor is stopped
   assign sys_sound = {keybeep, 9'd0} + {1'b0, tape_in && !tape_motor_on, 8'd0};

   // Sign-extend each device sample before the add
   assign sum_l = {device_sound_l[15], device_sound_l} + {7'd0, sys_sound};
   assign sum_r = {device_sound_r[15], device_sound_r} + {7'd0, sys_sound};

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         audio_l <= '0;
         audio_r <= '0;
      end else begin
         audio_l <= saturate(sum_l);
         audio_r <= saturate(sum_r);
      end
   end

endmodule

//--- rtl/msx_core.sv
`timescale 1ns/10ps

module msx_core #(
   parameter int RAM_AW = 8
) (
   input  logic              clock_bus,
   input  logic              rst,
   // CPU bus
   input  msx_pkg::addr_t    addr,
   input  msx_pkg::data_t    cpu_dout,
   input  logic              mreq,
   input  logic              iorq,
   input  logic              m1,
   input  logic              rd,
   input  logic              wr,
   output msx_pkg::data_t    cpu_din,
   // Wait control
   input  msx_pkg::wait_t    wait_cfg,
   input  logic              ext_wait,
   output logic              wait_n,
   // Sound and cassette
   input  msx_pkg::sample_t  device_sound_l,
   input  msx_pkg::sample_t  device_sound_r,
   input  logic              tape_in,
   output logic              tape_motor_on,
   output msx_pkg::sample_t  audio_l,
   output msx_pkg::sample_t  audio_r
);

   import msx_pkg::*;

   logic  core_rst;
   logic  read_req;
   data_t ppi_data;
   logic  ppi_oe;
   data_t slot_data;
   logic  slot_oe;
   slot_t active_slot;
   logic  keybeep;

   // Core reset trails rst by one cycle
   always_ff @(posedge clock_bus) begin
      core_rst <= rst;
   end

   ppi_ports u_ppi_ports (
      .clock_bus     (clock_bus),
      .rst           (core_rst),
      .addr          (addr),
      .cpu_dout      (cpu_dout),
      .iorq          (iorq),
      .rd            (rd),
      .wr            (wr),
      .ppi_data      (ppi_data),
      .ppi_oe        (ppi_oe),
      .active_slot   (active_slot),
      .keybeep       (keybeep),
      .tape_motor_on (tape_motor_on)
   );

   slot_memory #(
      .RAM_AW (RAM_AW)
   ) u_slot_memory (
      .clock_bus   (clock_bus),
      .rst         (core_rst),
      .addr        (addr),
      .cpu_dout    (cpu_dout),
      .mreq        (mreq),
      .rd          (rd),
      .wr          (wr),
      .active_slot (active_slot),
      .slot_data   (slot_data),
      .slot_oe     (slot_oe)
   );

   wait_gen u_wait_gen (
      .clock_bus (clock_bus),
      .rst       (core_rst),
      .m1        (m1),
      .wait_cfg  (wait_cfg),
      .ext_wait  (ext_wait),
      .wait_n    (wait_n)
   );

   audio_mix u_audio_mix (
      .clock_bus      (clock_bus),
      .rst            (core_rst),
      .device_sound_l (device_sound_l),
      .device_sound_r (device_sound_r),
      .keybeep        (keybeep),
      .tape_in        (tape_in),
      .tape_motor_on  (tape_motor_on),
      .audio_l        (audio_l),
      .audio_r        (audio_r)
   );

   // Interrupt acknowledge counts as a read and floats to FFh
   assign read_req = rd || (iorq && m1);

   // I/O ports win over memory and an open bus reads FFh
   always_comb begin
      if (!read_req) begin
         cpu_din = 8'hFF;
      end else if (ppi_oe) begin
         cpu_din = ppi_data;
      end else if (slot_oe) begin
         cpu_din = slot_data;
      end else begin
         cpu_din = 8'hFF;
      end
   end

endmodule

//--- rtl/msx_pkg.sv
package msx_pkg;

   // CPU bus address and data
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // Primary slot number for one 16 KB page
   typedef logic [1:0]  slot_t;

   // Primary slot register with two bits per page and page 0 in bits 1:0
   typedef logic [7:0]  slot_cfg_t;

   // Signed audio sample of one channel
   typedef logic signed [15:0] sample_t;

   // Number of wait cycles after an M1 rise
   typedef logic [2:0]  wait_t;

   // I/O port addresses matched against addr[7:0]
   localparam data_t PORT_SLOT  = 8'hA8;
   localparam data_t PORT_PPI_C = 8'hAA;

   // Port C bit positions
   localparam int PPI_C_MOTOR_BIT = 4;
   localparam int PPI_C_CLICK_BIT = 7;

endpackage

//--- rtl/ppi_ports.sv
`timescale 1ns/10ps

module ppi_ports (
   input  logic             clock_bus,
   input  logic             rst,
   input  msx_pkg::addr_t   addr,
   input  msx_pkg::data_t   cpu_dout,
   input  logic             iorq,
   input  logic             rd,
   input  logic             wr,
   output msx_pkg::data_t   ppi_data,
   output logic             ppi_oe,
   output msx_pkg::slot_t   active_slot,
   output logic             keybeep,
   output logic             tape_motor_on
);

   import msx_pkg::*;

   slot_cfg_t slot_cfg;
   data_t     port_c;

   logic hit_slot;
   logic hit_port_c;
   logic port_rd;

   // Port decode on the low address byte only
   assign hit_slot   = iorq && (addr[7:0] == PORT_SLOT);
   assign hit_port_c = iorq && (addr[7:0] == PORT_PPI_C);
   assign port_rd    = rd && (hit_slot || hit_port_c);

   // Control registers and read strobe
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         slot_cfg <= '0;
         port_c   <= '0;
         ppi_oe   <= 1'b0;
      end else begin
         if (wr && hit_slot) begin
            slot_cfg <= cpu_dout;
         end
         if (wr && hit_port_c) begin
            port_c <= cpu_dout;
         end
         ppi_oe <= port_rd;
      end
   end

   // Read data is valid together with ppi_oe
   always_ff @(posedge clock_bus) begin
      if (port_rd) begin
         if (hit_slot) begin
            ppi_data <= slot_cfg;
         end else begin
            ppi_data <= port_c;
         end
      end
   end

   // Page select by addr[15:14]
   always_comb begin
      case (addr[15:14])
         2'd0:    active_slot = slot_cfg[1:0];
         2'd1:    active_slot = slot_cfg[3:2];
         2'd2:    active_slot = slot_cfg[5:4];
         default: active_slot = slot_cfg[7:6];
      endcase
   end

   assign keybeep = port_c[PPI_C_CLICK_BIT];

   // Motor bit is active low
   assign tape_motor_on = ~port_c[PPI_C_MOTOR_BIT];

endmodule

//--- rtl/slot_memory.sv
`timescale 1ns/10ps

module slot_memory #(
   parameter int RAM_AW = 8
) (
   input  logic             clock_bus,
   input  logic             rst,
   input  msx_pkg::addr_t   addr,
   input  msx_pkg::data_t   cpu_dout,
   input  logic             mreq,
   input  logic             rd,
   input  logic             wr,
   input  msx_pkg::slot_t   active_slot,
   output msx_pkg::data_t   slot_data,
   output logic             slot_oe
);

   import msx_pkg::*;

   localparam int   RAM_DEPTH  = 1 << RAM_AW;
   localparam int   RAM_SLOTS  = 3;
   localparam slot_t SLOT_EMPTY = 2'd3;

   // One RAM per populated slot
   data_t ram [0:RAM_SLOTS-1][0:RAM_DEPTH-1];

   logic [RAM_AW-1:0] ram_addr;
   logic              slot_present;
   logic              mem_wr;
   logic              mem_rd;

   // High address bits alias onto the small RAM
   assign ram_addr     = addr[RAM_AW-1:0];
   assign slot_present = (active_slot != SLOT_EMPTY);
   assign mem_wr       = mreq && wr && slot_present;
   assign mem_rd       = mreq && rd && slot_present;

   // RAM write and registered read
   always_ff @(posedge clock_bus) begin
      if (mem_wr) begin
         ram[active_slot][ram_addr] <= cpu_dout;
      end
      if (mem_rd) begin
         slot_data <= ram[active_slot][ram_addr];
      end
   end

   // Output enable follows the read one cycle later
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         slot_oe <= 1'b0;
      end else begin
         slot_oe <= mem_rd;
      end
   end

endmodule

//--- rtl/wait_gen.sv
`timescale 1ns/10ps

module wait_gen (
   input  logic             clock_bus,
   input  logic             rst,
   input  logic             m1,
   input  msx_pkg::wait_t   wait_cfg,
   input  logic             ext_wait,
   output logic             wait_n
);

   import msx_pkg::*;

   logic  m1_prev;
   logic  m1_rise;
   wait_t wait_count;

   assign m1_rise = m1 && !m1_prev;

   // Down-counter loaded on each M1 rise
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         m1_prev    <= 1'b0;
         wait_count <= '0;
      end else begin
         m1_prev <= m1;
         if (m1_rise) begin
            wait_count <= wait_cfg;
         end else if (wait_count != '0) begin
            wait_count <= wait_count - 3'd1;
         end
      end
   end

   // External wait acts in the same cycle
   assign wait_n = (wait_count == '0) && !ext_wait;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the msx_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 -f list.f --top-module tb_msx_core \
   --Mdir "$BUILD_DIR" -o tb_msx_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_msx_core" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test OK" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/msx_vectors.txt
# W addr data | R addr expected | O port data | I port expected | S sweep count (hex)
# F wait_cfg | E ext_wait cycles | A left right tape expected_left expected_right
# Slot register and port C
O A8 5A
I A8 5A
O AA 00
I AA 00
O A8 00
# Same address through each slot
W 0010 11
O A8 01
W 0010 22
O A8 02
W 0010 33
O A8 03
W 0010 44
R 0010 FF
O A8 00
R 0010 11
O A8 02
R 0010 33
O A8 01
R 0010 22
R 0110 22
# One slot per page
O A8 E4
I A8 E4
W 4020 55
W 8020 66
W C020 77
R 4020 55
R 8020 66
R C020 FF
R 4010 22
R 8010 33
# Random sweeps under two mappings
S 14
O A8 1B
S 14
# Wait states
F 0
F 3
F 7
E 4
F 2
# Click on, motor on
O AA 80
I AA 80
A 0000 0000 0 0400 0400
A 0000 0000 1 0400 0400
# Motor off
O AA 10
A 0000 0000 1 0200 0200
A 0000 0000 0 0000 0000
O AA 90
A 0000 0000 1 0600 0600
A 1000 F000 0 2400 E400
A 3E00 C200 0 7FFF 8800
A 3DFF C000 0 7FFE 8400
A 7FFF 8000 1 7FFF 8000
O AA 00
A 8000 8000 1 8000 8000
A BFFF 4000 0 8000 7FFF
A C000 3FFF 0 8000 7FFE
A 0123 FEDC 0 0246 FDB8

//--- sim/tb_msx_core.sv
`timescale 1ns/10ps

module tb_msx_core;

   import msx_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 8;
   localparam int RAM_AW       = 8;
   localparam int WAIT_LIMIT   = 7;
   localparam int LINE_LIMIT   = 256;

   logic    clock_bus;
   logic    rst;
   addr_t   addr;
   data_t   cpu_dout;
   logic    mreq;
   logic    iorq;
   logic    m1;
   logic    rd;
   logic    wr;
   wait_t   wait_cfg;
   logic    ext_wait;
   sample_t device_sound_l;
   sample_t device_sound_r;
   logic    tape_in;
   data_t   cpu_din;
   logic    wait_n;
   logic    tape_motor_on;
   sample_t audio_l;
   sample_t audio_r;

   // Reference model of the bus-visible state
   slot_cfg_t   model_slot_cfg;
   data_t       model_port_c;
   data_t       model_ram [0:2][0:(1<<RAM_AW)-1];
   logic [15:0] lfsr_state;

   msx_core u_dut (
      .clock_bus      (clock_bus),
      .rst            (rst),
      .addr           (addr),
      .cpu_dout       (cpu_dout),
      .mreq           (mreq),
      .iorq           (iorq),
      .m1             (m1),
      .rd             (rd),
      .wr             (wr),
      .cpu_din        (cpu_din),
      .wait_cfg       (wait_cfg),
      .ext_wait       (ext_wait),
      .wait_n         (wait_n),
      .device_sound_l (device_sound_l),
      .device_sound_r (device_sound_r),
      .tape_in        (tape_in),
      .tape_motor_on  (tape_motor_on),
      .audio_l        (audio_l),
      .audio_r        (audio_r)
   );

   initial begin
      clock_bus = 1'b0;
      forever #(CLK_PERIOD / 2) clock_bus = ~clock_bus;
   end

   task automatic stop_with_failure();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_wait(input string name, input wait_t got, input wait_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   // Step to the drive point just after the rising edge
   task automatic next_cycle();
      @(posedge clock_bus);
      #DRIVE_DELAY;
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic take_bits(input int count, output logic [15:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[14:0], lfsr_state[0]};
      end
   endtask

   function automatic slot_t model_slot(input addr_t a);
      case (a[15:14])
         2'd0:    return model_slot_cfg[1:0];
         2'd1:    return model_slot_cfg[3:2];
         2'd2:    return model_slot_cfg[5:4];
         default: return model_slot_cfg[7:6];
      endcase
   endfunction

   function automatic data_t model_read(input addr_t a);
      slot_t s;
      s = model_slot(a);
      if (s == 2'd3) begin
         return 8'hFF;
      end
      return model_ram[s][a[RAM_AW-1:0]];
   endfunction

   // Click adds 512 and tape adds 256 with the motor off, then doubled or clipped
   function automatic sample_t expected_sample(input sample_t dev, input logic tape);
      int sum;
      int twice;
      sum = int'(dev);
      if (model_port_c[7]) sum = sum + 512;
      if (tape && model_port_c[4]) sum = sum + 256;
      if (sum > 16383) return 16'h7FFF;
      if (sum < -16384) return 16'h8000;
      twice = sum * 2;
      return twice[15:0];
   endfunction

   task automatic mem_write(input addr_t a, input data_t d);
      slot_t s;
      s = model_slot(a);
      addr = a;
      cpu_dout = d;
      mreq = 1'b1;
      wr = 1'b1;
      next_cycle();
      mreq = 1'b0;
      wr = 1'b0;
      if (s != 2'd3) model_ram[s][a[RAM_AW-1:0]] = d;
      next_cycle();
   endtask

   task automatic mem_read(input addr_t a, input data_t exp);
      addr = a;
      mreq = 1'b1;
      rd = 1'b1;
      next_cycle();
      check_data("cpu_din", cpu_din, exp);
      mreq = 1'b0;
      rd = 1'b0;
      // Bus returns FFh as soon as the read strobe drops
      #1;
      check_data("cpu_din", cpu_din, 8'hFF);
      next_cycle();
   endtask

   task automatic io_write(input data_t port, input data_t d);
      addr = {8'h00, port};
      cpu_dout = d;
      iorq = 1'b1;
      wr = 1'b1;
      next_cycle();
      iorq = 1'b0;
      wr = 1'b0;
      if (port == PORT_SLOT) model_slot_cfg = d;
      if (port == PORT_PPI_C) model_port_c = d;
      check_bit("tape_motor_on", tape_motor_on, ~model_port_c[4]);
      next_cycle();
   endtask

   task automatic io_read(input data_t port, input data_t exp);
      addr = {8'h00, port};
      iorq = 1'b1;
      rd = 1'b1;
      next_cycle();
      check_data("cpu_din", cpu_din, exp);
      iorq = 1'b0;
      rd = 1'b0;
      #1;
      check_data("cpu_din", cpu_din, 8'hFF);
      next_cycle();
   endtask

   task automatic m1_fetch(input wait_t cfg);
      int low_cycles;
      low_cycles = 0;
      wait_cfg = cfg;
      m1 = 1'b1;
      next_cycle();
      while (!wait_n) begin
         low_cycles++;
         if (low_cycles > WAIT_LIMIT) begin
            $display("Timeout: wait_n stayed low for more than %0d cycles after M1", WAIT_LIMIT);
            stop_with_failure();
         end
         next_cycle();
      end
      check_wait("wait_n low cycles", low_cycles[2:0], cfg);
      m1 = 1'b0;
      next_cycle();
   endtask

   task automatic ext_wait_hold(input int cycles);
      ext_wait = 1'b1;
      for (int i = 0; i < cycles; i++) begin
         #1;
         check_bit("wait_n", wait_n, 1'b0);
         next_cycle();
      end
      ext_wait = 1'b0;
      #1;
      check_bit("wait_n", wait_n, 1'b1);
      next_cycle();
   endtask

   task automatic audio_case(input sample_t l, input sample_t r, input logic tape,
                             input sample_t exp_l, input sample_t exp_r);
      check_sample("vector audio_l", exp_l, expected_sample(l, tape));
      check_sample("vector audio_r", exp_r, expected_sample(r, tape));
      device_sound_l = l;
      device_sound_r = r;
      tape_in = tape;
      next_cycle();
      check_sample("audio_l", audio_l, exp_l);
      check_sample("audio_r", audio_r, exp_r);
   endtask

   // Random writes first and then a read of every address
   task automatic sweep(input int count);
      addr_t       a_q[$];
      logic [15:0] a;
      logic [15:0] d;
      for (int i = 0; i < count; i++) begin
         take_bits(16, a);
         take_bits(8, d);
         mem_write(a, d[7:0]);
         a_q.push_back(a);
      end
      foreach (a_q[i]) begin
         mem_read(a_q[i], model_read(a_q[i]));
      end
   endtask

   task automatic bad_line(input logic [7:0] op);
      $display("Vector line for operation %s has missing fields", op);
      stop_with_failure();
   endtask

   initial begin
      int          fd;
      int          code;
      int          c;
      int          ops;
      logic [7:0]  op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      rst = 1'b1;
      addr = '0;
      cpu_dout = '0;
      mreq = 1'b0;
      iorq = 1'b0;
      m1 = 1'b0;
      rd = 1'b0;
      wr = 1'b0;
      wait_cfg = '0;
      ext_wait = 1'b0;
      device_sound_l = '0;
      device_sound_r = '0;
      tape_in = 1'b0;
      model_slot_cfg = '0;
      model_port_c = '0;
      lfsr_state = 16'd54086;
      ops = 0;
      repeat (RESET_CYCLES) @(posedge clock_bus);
      #DRIVE_DELAY;
      rst = 1'b0;
      // Core reset trails by one cycle and audio by one more
      repeat (3) next_cycle();
      check_data("cpu_din", cpu_din, 8'hFF);
      check_bit("wait_n", wait_n, 1'b1);
      check_bit("tape_motor_on", tape_motor_on, 1'b1);
      check_sample("audio_l", audio_l, 16'h0000);
      check_sample("audio_r", audio_r, 16'h0000);

      fd = $fopen("sim/msx_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open sim/msx_vectors.txt");
         stop_with_failure();
      end
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
         case (op)
            "#": begin
               c = 0;
               for (int i = 0; i < LINE_LIMIT && c != 10 && c != -1; i++) begin
                  c = $fgetc(fd);
               end
            end
            "W": begin
               if ($fscanf(fd, "%h %h", f1, f2) != 2) bad_line(op);
               mem_write(f1[15:0], f2[7:0]);
            end
            "R": begin
               if ($fscanf(fd, "%h %h", f1, f2) != 2) bad_line(op);
               check_data("vector memory data", f2[7:0], model_read(f1[15:0]));
               mem_read(f1[15:0], f2[7:0]);
            end
            "O": begin
               if ($fscanf(fd, "%h %h", f1, f2) != 2) bad_line(op);
               io_write(f1[7:0], f2[7:0]);
            end
            "I": begin
               if ($fscanf(fd, "%h %h", f1, f2) != 2) bad_line(op);
               if (f1[7:0] == PORT_SLOT) begin
                  check_data("vector port A8h", f2[7:0], model_slot_cfg);
               end else begin
                  check_data("vector port AAh", f2[7:0], model_port_c);
               end
               io_read(f1[7:0], f2[7:0]);
            end
            "F": begin
               if ($fscanf(fd, "%h", f1) != 1) bad_line(op);
               m1_fetch(f1[2:0]);
            end
            "E": begin
               if ($fscanf(fd, "%h", f1) != 1) bad_line(op);
               ext_wait_hold(int'(f1[7:0]));
            end
            "S": begin
               if ($fscanf(fd, "%h", f1) != 1) bad_line(op);
               sweep(int'(f1[7:0]));
            end
            "A": begin
               if ($fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5) != 5) bad_line(op);
               audio_case(f1[15:0], f2[15:0], f3[0], f4[15:0], f5[15:0]);
            end
            default: begin
               $display("Unknown operation %s in the vector file", op);
               stop_with_failure();
            end
         endcase
         if (op != "#") ops++;
         code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
      if (ops == 0) begin
         $display("No operations were read from the vector file");
         stop_with_failure();
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule
